/* Bender.yml */
package:
  name: tdc_ctrl

sources:
  - files:
      - common/tdc_ctrl_pkg.sv
      - hw/uart_rx.sv
      - hw/main_control.sv
      - hw/meas_trigger.sv
      - hw/tdc_ctrl_top.sv
  - target: test
    files:
      - testbench/tb_tdc_ctrl_top.sv

/* build.f */
common/tdc_ctrl_pkg.sv
hw/uart_rx.sv
hw/main_control.sv
hw/meas_trigger.sv
hw/tdc_ctrl_top.sv
testbench/tb_tdc_ctrl_top.sv

/* common/tdc_ctrl_pkg.sv */
package tdc_ctrl_pkg;

  // Widths that carry a meaning
  typedef logic [7:0]  byte_t;        // One received UART byte
  typedef logic [19:0] wait_cnt_t;    // Boot wait counter, up to about 20 ms
  typedef logic [9:0]  period_cnt_t;  // Trigger period counter

  // UART timing, 115200 baud at 50 MHz
  localparam int clks_per_bit = 434;

  // TDC boot time after the enable rises, 2 ms at 50 MHz
  // The TDC needs roughly 1.7 ms before it accepts a soft reset
  localparam int enable_wait_cycles = 100000;

  // Interval between two start pulses
  localparam int trigger_period_cycles = 1000;

  // Host command bytes
  localparam byte_t cmd_boot  = 8'h64;  // ASCII "d"
  localparam byte_t cmd_play  = 8'h70;  // ASCII "p"
  localparam byte_t cmd_pause = 8'h73;  // ASCII "s"

  // Power-up sequencer of main_control
  typedef enum logic [1:0] {
    idle,
    enable_low,
    enable_high,
    soft_reset
  } ctrl_state_t;

endpackage

/* hw/main_control.sv */
`timescale 1ns/1ns

// Command decoder and TDC power-up sequencer
module main_control (
  input  logic                clk,
  input  logic                rst,
  input  tdc_ctrl_pkg::byte_t rx_data,
  input  logic                rx_valid,
  output logic                tdc_enable,
  output logic                soft_reset,
  output logic                play,
  output logic                pause
);

  tdc_ctrl_pkg::ctrl_state_t state_d, state_q;
  tdc_ctrl_pkg::wait_cnt_t   wait_cnt_d, wait_cnt_q;

  logic enable_d, enable_q;
  logic soft_reset_d, soft_reset_q;
  logic play_d, play_q;
  logic pause_d, pause_q;

  logic is_boot;
  logic is_play;
  logic is_pause;
  logic wait_done;

  assign is_boot  = rx_valid && (rx_data == tdc_ctrl_pkg::cmd_boot);
  assign is_play  = rx_valid && (rx_data == tdc_ctrl_pkg::cmd_play);
  assign is_pause = rx_valid && (rx_data == tdc_ctrl_pkg::cmd_pause);

  // Last cycle of the boot wait, soft reset follows in the next one
  assign wait_done =
    (wait_cnt_q == tdc_ctrl_pkg::wait_cnt_t'(tdc_ctrl_pkg::enable_wait_cycles - 1));

  assign tdc_enable = enable_q;
  assign soft_reset = soft_reset_q;
  assign play       = play_q;
  assign pause      = pause_q;

  always_comb begin
    state_d      = state_q;
    wait_cnt_d   = wait_cnt_q;
    enable_d     = enable_q;
    soft_reset_d = 1'b0;  // Pulse only
    play_d       = play_q;
    pause_d      = pause_q;

    case (state_q)
      tdc_ctrl_pkg::idle: begin
        // Bytes are only looked at here, anything else is dropped
        if (is_boot) begin
          enable_d = 1'b0;
          state_d  = tdc_ctrl_pkg::enable_low;
        end else if (is_play) begin
          play_d  = 1'b1;
          pause_d = 1'b0;
        end else if (is_pause) begin
          play_d  = 1'b0;
          pause_d = 1'b1;
        end
      end

      tdc_ctrl_pkg::enable_low: begin
        enable_d   = 1'b1;  // Low-to-high edge powers the TDC up
        wait_cnt_d = '0;
        state_d    = tdc_ctrl_pkg::enable_high;
      end

      tdc_ctrl_pkg::enable_high: begin
        if (wait_done) begin
          soft_reset_d = 1'b1;
          state_d      = tdc_ctrl_pkg::soft_reset;
        end else begin
          wait_cnt_d = wait_cnt_q + 1'b1;
        end
      end

      tdc_ctrl_pkg::soft_reset: begin
        state_d = tdc_ctrl_pkg::idle;
      end

      default: begin
        state_d = tdc_ctrl_pkg::idle;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q      <= tdc_ctrl_pkg::idle;
      wait_cnt_q   <= '0;
      enable_q     <= 1'b0;
      soft_reset_q <= 1'b0;
      play_q       <= 1'b0;
      pause_q      <= 1'b0;
    end else begin
      state_q      <= state_d;
      wait_cnt_q   <= wait_cnt_d;
      enable_q     <= enable_d;
      soft_reset_q <= soft_reset_d;
      play_q       <= play_d;
      pause_q      <= pause_d;
    end
  end

  // Soft reset lands on a TDC that has been enabled for the whole boot wait
  soft_reset_after_enable: assert property (
    @(posedge clk) disable iff (rst)
    soft_reset |-> tdc_enable && $past(tdc_enable)
  );

  play_pause_exclusive: assert property (
    @(posedge clk) disable iff (rst)
    !(play && pause)
  );

endmodule

/* hw/meas_trigger.sv */
`timescale 1ns/1ns

// Periodic TDC start pulse while play is active
module meas_trigger (
  input  logic clk,
  input  logic rst,
  input  logic play,
  output logic start
);

  tdc_ctrl_pkg::period_cnt_t period_cnt;

  logic play_q;
  logic play_rise;
  logic period_wrap;
  logic start_q;

  assign play_rise   = play & ~play_q;
  assign period_wrap =
    (period_cnt == tdc_ctrl_pkg::period_cnt_t'(tdc_ctrl_pkg::trigger_period_cycles - 1));

  // A pulse scheduled in the cycle play drops is swallowed
  assign start = start_q & play;

  always_ff @(posedge clk) begin
    if (rst) begin
      play_q     <= 1'b0;
      period_cnt <= '0;
      start_q    <= 1'b0;
    end else begin
      play_q <= play;

      if (!play) begin
        period_cnt <= '0;  // Stopped and cleared
        start_q    <= 1'b0;
      end else if (play_rise) begin
        period_cnt <= '0;
        start_q    <= 1'b1;  // First pulse one cycle after the edge
      end else if (period_wrap) begin
        period_cnt <= '0;
        start_q    <= 1'b1;
      end else begin
        period_cnt <= period_cnt + 1'b1;
        start_q    <= 1'b0;
      end
    end
  end

  // Never a pulse on the first cycle of play, it always follows the edge
  start_inside_play: assert property (
    @(posedge clk) disable iff (rst)
    start |-> play && $past(play)
  );

endmodule

/* hw/tdc_ctrl_top.sv */
`timescale 1ns/1ns

// TDC control front end: UART commands in, TDC control levels out
module tdc_ctrl_top (
  input  logic clk,
  input  logic rst,
  input  logic uart_rxd,
  output logic tdc_enable,
  output logic tdc_soft_reset,
  output logic tdc_start,
  output logic play,
  output logic pause
);

  tdc_ctrl_pkg::byte_t rx_data;
  logic                rx_valid;  // One cycle, no back-pressure
  logic                play_lvl;

  assign play = play_lvl;

  uart_rx i_uart_rx (
    .clk   (clk),
    .rst   (rst),
    .rxd   (uart_rxd),
    .data  (rx_data),
    .valid (rx_valid)
  );

  main_control i_main_control (
    .clk        (clk),
    .rst        (rst),
    .rx_data    (rx_data),
    .rx_valid   (rx_valid),
    .tdc_enable (tdc_enable),
    .soft_reset (tdc_soft_reset),
    .play       (play_lvl),
    .pause      (pause)
  );

  // Start pulses run off the play level only
  meas_trigger i_meas_trigger (
    .clk   (clk),
    .rst   (rst),
    .play  (play_lvl),
    .start (tdc_start)
  );

endmodule

/* hw/uart_rx.sv */
`timescale 1ns/1ns

// 8N1 receiver, fixed baud rate
module uart_rx (
  input  logic                clk,
  input  logic                rst,
  input  logic                rxd,
  output tdc_ctrl_pkg::byte_t data,
  output logic                valid
);

  typedef enum logic [1:0] {
    st_idle,
    st_start,
    st_bits,
    st_stop
  } rx_state_t;

  typedef logic [$clog2(tdc_ctrl_pkg::clks_per_bit)-1:0] baud_cnt_t;

  logic [1:0]          rxd_sync;   // Two-flop synchronizer
  logic                rxd_prev;   // Last synchronized level
  rx_state_t           state;
  baud_cnt_t           baud_cnt;
  logic [2:0]          bit_idx;
  tdc_ctrl_pkg::byte_t shift;

  logic rxd_s;
  logic fall;
  logic half_bit;
  logic full_bit;

  assign rxd_s = rxd_sync[1];
  assign fall  = rxd_prev & ~rxd_s;  // Start bit begins

  // Middle of the start bit, counted from the falling edge
  assign half_bit = (baud_cnt == baud_cnt_t'(tdc_ctrl_pkg::clks_per_bit / 2 - 1));
  // One full bit on from the last sampling point, so again mid-bit
  assign full_bit = (baud_cnt == baud_cnt_t'(tdc_ctrl_pkg::clks_per_bit - 1));

  always_ff @(posedge clk) begin
    if (rst) begin
      rxd_sync <= 2'b11;  // Idle line is high
      rxd_prev <= 1'b1;
    end else begin
      rxd_sync <= {rxd_sync[0], rxd};
      rxd_prev <= rxd_s;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= st_idle;
      baud_cnt <= '0;
      bit_idx  <= '0;
      shift    <= '0;
      data     <= '0;
      valid    <= 1'b0;
    end else begin
      valid <= 1'b0;

      case (state)
        st_idle: begin
          baud_cnt <= '0;
          bit_idx  <= '0;
          if (fall) begin
            state <= st_start;
          end
        end

        st_start: begin
          if (half_bit) begin
            baud_cnt <= '0;
            // A start bit that is gone again by mid-bit was a glitch
            state <= rxd_s ? st_idle : st_bits;
          end else begin
            baud_cnt <= baud_cnt + 1'b1;
          end
        end

        st_bits: begin
          if (full_bit) begin
            baud_cnt <= '0;
            shift    <= {rxd_s, shift[7:1]};  // LSB arrives first
            bit_idx  <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) begin
              state <= st_stop;
            end
          end else begin
            baud_cnt <= baud_cnt + 1'b1;
          end
        end

        st_stop: begin
          if (full_bit) begin
            baud_cnt <= '0;
            state    <= st_idle;
            // Framing error drops the byte silently
            if (rxd_s) begin
              data  <= shift;
              valid <= 1'b1;
            end
          end else begin
            baud_cnt <= baud_cnt + 1'b1;
          end
        end

        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  // One strobe per frame, a frame lasts far longer than one cycle
  valid_one_cycle: assert property (
    @(posedge clk) disable iff (rst)
    valid |=> !valid
  );

endmodule

/* testbench/tb_tdc_ctrl_top.sv */
`timescale 1ns/1ns

module tb_tdc_ctrl_top;

  typedef enum logic [1:0] {
    row_cmd,       // Good frame carrying the row's byte
    row_bad_stop,  // Row's byte with a stop bit of 0
    row_filler     // Random byte that is no command
  } row_kind_t;

  typedef struct packed {
    row_kind_t           kind;
    tdc_ctrl_pkg::byte_t data;
    logic [31:0]         wait_cycles;
    logic                exp_play;
    logic                exp_pause;
    logic                exp_enable;
  } row_t;

  localparam int num_rows = 11;

  logic clk;
  logic rst;
  logic uart_rxd;
  logic tdc_enable;
  logic tdc_soft_reset;
  logic tdc_start;
  logic play;
  logic pause;

  row_t   rows [0:num_rows-1];
  integer seed = 32'h8969;
  logic   table_ready = 1'b0;
  int     errors = 0;
  int     tests_passed = 0;
  int     tests_failed = 0;

  // Monitor state
  longint cycle = 0;
  longint enable_rise_cycle = 0;
  longint play_rise_cycle = 0;
  longint last_start_cycle = 0;
  int     enable_rises = 0;
  int     enable_falls = 0;
  int     soft_resets = 0;
  int     start_count = 0;
  logic   enable_prev = 1'b0;
  logic   soft_prev = 1'b0;
  logic   play_prev = 1'b0;
  logic   first_start_pending = 1'b0;

  tdc_ctrl_top i_dut (
    .clk            (clk),
    .rst            (rst),
    .uart_rxd       (uart_rxd),
    .tdc_enable     (tdc_enable),
    .tdc_soft_reset (tdc_soft_reset),
    .tdc_start      (tdc_start),
    .play           (play),
    .pause          (pause)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic check_level(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      errors++;
      $display("mismatch at %0t: %s expected %b actual %b", $time, name, exp, act);
    end
  endtask

  task automatic check_count(input string name, input longint exp, input longint act);
    if (act != exp) begin
      errors++;
      $display("mismatch at %0t: %s expected %0d actual %0d", $time, name, exp, act);
    end
  endtask

  task automatic report_error(input string what);
    errors++;
    $display("error at %0t: %s", $time, what);
  endtask

  // Start bit, 8 data bits LSB first, stop bit, then one idle bit
  task automatic send_frame(input tdc_ctrl_pkg::byte_t b, input logic stop);
    logic [10:0] bits;
    bits = {1'b1, stop, b, 1'b0};
    for (int i = 0; i < 11; i++) begin
      @(posedge clk);
      uart_rxd <= bits[i];
      repeat (tdc_ctrl_pkg::clks_per_bit - 1) @(posedge clk);
    end
  endtask

  task automatic next_filler(output tdc_ctrl_pkg::byte_t b);
    b = tdc_ctrl_pkg::cmd_boot;
    while (b == tdc_ctrl_pkg::cmd_boot || b == tdc_ctrl_pkg::cmd_play ||
           b == tdc_ctrl_pkg::cmd_pause) begin
      b = $random(seed);
    end
  endtask

  task automatic load_table();
    rows[0]  = {row_cmd,      tdc_ctrl_pkg::cmd_play,  32'd100,    3'b100};
    rows[1]  = {row_filler,   8'h00,                   32'd100,    3'b100};
    rows[2]  = {row_cmd,      tdc_ctrl_pkg::cmd_pause, 32'd2500,   3'b010};
    rows[3]  = {row_filler,   8'h00,                   32'd100,    3'b010};
    rows[4]  = {row_bad_stop, tdc_ctrl_pkg::cmd_play,  32'd100,    3'b010};
    rows[5]  = {row_cmd,      tdc_ctrl_pkg::cmd_boot,  32'd2000,   3'b011};
    rows[6]  = {row_cmd,      tdc_ctrl_pkg::cmd_play,  32'd100000, 3'b011};  // Inside boot wait
    rows[7]  = {row_cmd,      tdc_ctrl_pkg::cmd_play,  32'd3500,   3'b101};
    rows[8]  = {row_cmd,      tdc_ctrl_pkg::cmd_boot,  32'd103000, 3'b101};  // Reboot while playing
    rows[9]  = {row_cmd,      tdc_ctrl_pkg::cmd_pause, 32'd2500,   3'b011};
    rows[10] = {row_filler,   8'h00,                   32'd100,    3'b011};
  endtask

  // Sampled on the falling edge, away from the DUT's register updates
  always @(negedge clk) begin
    cycle = cycle + 1;
    if (!rst) begin
      if (tdc_enable && !enable_prev) begin
        enable_rises++;
        enable_rise_cycle = cycle;
      end
      if (!tdc_enable && enable_prev) begin
        enable_falls++;
      end
      if (tdc_soft_reset) begin
        soft_resets++;
        if (soft_prev) begin
          report_error("soft reset stayed high for more than one cycle");
        end else begin
          check_count("soft reset delay", tdc_ctrl_pkg::enable_wait_cycles,
                      cycle - enable_rise_cycle);
        end
      end
      if (play && !play_prev) begin
        play_rise_cycle     = cycle;
        first_start_pending = 1'b1;
      end
      if (tdc_start) begin
        start_count++;
        if (!play) begin
          report_error("start pulse while play is low");
        end else if (first_start_pending) begin
          check_count("first start delay", 1, cycle - play_rise_cycle);
          first_start_pending = 1'b0;
        end else begin
          check_count("start period", tdc_ctrl_pkg::trigger_period_cycles,
                      cycle - last_start_cycle);
        end
        last_start_cycle = cycle;
      end
    end
    enable_prev = tdc_enable;
    soft_prev   = tdc_soft_reset;
    play_prev   = play;
  end

  // Budget covers the reset check, all frames and waits, two boots and a margin
  initial begin
    longint limit;
    wait (table_ready);
    limit = 100 + 20000 + 2 * (tdc_ctrl_pkg::enable_wait_cycles + 2);
    for (int i = 0; i < num_rows; i++) begin
      limit += 11 * tdc_ctrl_pkg::clks_per_bit + rows[i].wait_cycles;
    end
    repeat (limit) @(posedge clk);
    $display("Timeout after %0d cycles, the run did not complete", limit);
    $display("Something failed");
    $finish;
  end

  initial begin
    tdc_ctrl_pkg::byte_t b;
    int                  errors_before;
    int                  starts_before;
    rst      = 1'b1;
    uart_rxd = 1'b1;  // Idle line
    load_table();
    table_ready = 1'b1;
    repeat (8) @(posedge clk);
    rst <= 1'b0;

    // All outputs stay low while the line is idle
    errors_before = errors;
    repeat (50) begin
      @(negedge clk);
      check_level("tdc_enable", 1'b0, tdc_enable);
      check_level("tdc_soft_reset", 1'b0, tdc_soft_reset);
      check_level("tdc_start", 1'b0, tdc_start);
      check_level("play", 1'b0, play);
      check_level("pause", 1'b0, pause);
    end
    if (errors == errors_before) begin
      tests_passed++;
      $display("test reset: passed");
    end else begin
      tests_failed++;
      $display("test reset: failed");
    end

    for (int i = 0; i < num_rows; i++) begin
      errors_before = errors;
      b = rows[i].data;
      if (rows[i].kind == row_filler) begin
        next_filler(b);
      end
      send_frame(b, rows[i].kind != row_bad_stop);
      starts_before = start_count;
      repeat (rows[i].wait_cycles) @(posedge clk);
      @(negedge clk);
      check_level("play", rows[i].exp_play, play);
      check_level("pause", rows[i].exp_pause, pause);
      check_level("tdc_enable", rows[i].exp_enable, tdc_enable);
      if (!rows[i].exp_play && start_count != starts_before) begin
        report_error("start pulses appeared while paused");
      end
      if (rows[i].exp_play && rows[i].wait_cycles >= tdc_ctrl_pkg::trigger_period_cycles &&
          start_count == starts_before) begin
        report_error("no start pulse while playing");
      end
      if (errors == errors_before) begin
        tests_passed++;
        $display("test %0d (byte %h): passed", i, b);
      end else begin
        tests_failed++;
        $display("test %0d (byte %h): failed", i, b);
      end
    end

    // Two boots, the second one from an enabled TDC
    errors_before = errors;
    check_count("soft reset pulses", 2, soft_resets);
    check_count("tdc_enable rises", 2, enable_rises);
    check_count("tdc_enable falls", 1, enable_falls);
    if (start_count == 0) begin
      report_error("no start pulse seen in the whole run");
    end
    if (errors == errors_before) begin
      tests_passed++;
      $display("test boot sequence: passed");
    end else begin
      tests_failed++;
      $display("test boot sequence: failed");
    end

    $display("tests passed %0d, tests failed %0d, errors %0d",
             tests_passed, tests_failed, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule
